// File: include/irq_defines.svh
`ifndef IRQ_DEFINES_SVH
`define IRQ_DEFINES_SVH

// Interrupt sources: clock, stopwatch, K0, K1, prog timer
`define IRQ_NUM_SRC 5

// Bank bit plus page of the interrupt vectors
// Vector = IRQ_VEC_PAGE + 2 * source code
`define IRQ_VEC_PAGE 13'h1100

// Core data path is one nibble wide
`define NIBBLE_W 4

// Program counter, bank bit included
`define PC_W 13

// Nibble stack pointer
`define SP_W 8

// Return address goes out as three nibbles, bank bit not stacked
`define PUSH_COUNT 3

`endif

// File: design/irq_src_pkg.sv
`include "irq_defines.svh"

package irq_src_pkg;

  // Source codes, a higher code wins
  typedef enum logic [2:0] {
    SRC_NONE      = 3'd0,
    SRC_CLOCK     = 3'd1,
    SRC_STOPWATCH = 3'd2,
    SRC_K0        = 3'd3,
    SRC_K1        = 3'd4,
    SRC_PROG      = 3'd6  // Code 5 is the serial port, not present
  } irq_src_t;

  // Full vector address, bank bit included
  typedef logic [`PC_W-1:0] irq_vec_t;

  // Flag index to source code
  // Index order matches src_event and src_mask
  localparam irq_src_t SRC_CODE [`IRQ_NUM_SRC] = '{
    SRC_CLOCK,
    SRC_STOPWATCH,
    SRC_K0,
    SRC_K1,
    SRC_PROG
  };

endpackage

// File: design/core_word_pkg.sv
`include "irq_defines.svh"

package core_word_pkg;

  // Nibble stack pointer
  typedef logic [`SP_W-1:0] sp_t;

  // Low 12 bits of the program counter
  // ps is the jump view (page and step within page)
  // nib is the stack view, nib[2] is pushed first
  typedef union packed {
    struct packed {
      logic [`NIBBLE_W-1:0]   page;
      logic [2*`NIBBLE_W-1:0] step;
    } ps;
    logic [`PUSH_COUNT-1:0][`NIBBLE_W-1:0] nib;
  } pc_word_u;

endpackage

// File: design/factor_latch.sv
`timescale 1ns/1ps
`include "irq_defines.svh"

// Stage 1 of the interrupt path
// Holds one interrupt factor flag per source
module factor_latch (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`IRQ_NUM_SRC-1:0] src_event,  // One-cycle pulses
  input  logic [`IRQ_NUM_SRC-1:0] src_mask,   // Mask levels, 1 enables
  input  logic                    ack_valid,
  input  irq_src_pkg::irq_src_t   ack_src,
  output logic [`IRQ_NUM_SRC-1:0] req_vec
);

  import irq_src_pkg::*;

  logic [`IRQ_NUM_SRC-1:0] flags;
  logic [`IRQ_NUM_SRC-1:0] ack_clr;

  // Acknowledged source code back to its flag bit
  always_comb begin
    ack_clr = '0;
    if (ack_valid) begin
      for (int i = 0; i < `IRQ_NUM_SRC; i++) begin
        if (SRC_CODE[i] == ack_src) begin
          ack_clr[i] = 1'b1;
        end
      end
    end
  end

  // Sticky flags
  // A new event in the ack cycle keeps its flag set
  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else begin
      flags <= (flags & ~ack_clr) | src_event;
    end
  end

  // Masked flags go straight on, no extra register here
  assign req_vec = flags & src_mask;

endmodule

// File: design/irq_priority.sv
`timescale 1ns/1ps
`include "irq_defines.svh"

// Stage 2 of the interrupt path
// Picks the highest pending source and registers it with its vector
module irq_priority (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`IRQ_NUM_SRC-1:0] req_vec,
  output logic                    req_any,
  output irq_src_pkg::irq_src_t   req_src,
  output irq_src_pkg::irq_vec_t   req_vector
);

  import irq_src_pkg::*;
  import core_word_pkg::*;

  localparam irq_vec_t VEC_PAGE = `IRQ_VEC_PAGE;

  logic     win_any;
  irq_src_t win_src;
  pc_word_u vec_word;

  // Codes rise with the flag index, so scan from the top bit down
  always_comb begin
    win_any = 1'b0;
    win_src = SRC_NONE;
    for (int i = `IRQ_NUM_SRC - 1; i >= 0; i--) begin
      if (req_vec[i] && !win_any) begin
        win_any = 1'b1;
        win_src = SRC_CODE[i];
      end
    end
  end

  // Vector within the fixed page, two words per source
  always_comb begin
    vec_word.ps.page = VEC_PAGE[11:8];
    vec_word.ps.step = VEC_PAGE[7:0] + {4'b0000, win_src, 1'b0};
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      req_any <= 1'b0;
      req_src <= SRC_NONE;
    end else begin
      req_any <= win_any;
      req_src <= win_src;
    end
  end

  always_ff @(posedge clk) begin
    req_vector <= {VEC_PAGE[12], vec_word};  // Bank bit from the page constant
  end

endmodule

// File: design/irq_sequencer.sv
`timescale 1ns/1ps
`include "irq_defines.svh"

// Stage 3 of the interrupt path
// Takes the interrupt at a boundary, pushes the return address, loads the vector
module irq_sequencer (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req_any,
  input  irq_src_pkg::irq_src_t req_src,
  input  irq_src_pkg::irq_vec_t req_vector,
  input  logic                  irq_enable,
  input  logic                  instr_done,
  input  logic                  halted,
  input  logic [`PC_W-1:0]      pc_in,
  input  core_word_pkg::sp_t    sp_in,
  output logic                  ack_valid,
  output irq_src_pkg::irq_src_t ack_src,
  output logic                  ie_clear,
  output logic                  stack_we,
  output core_word_pkg::sp_t    stack_addr,
  output logic [`NIBBLE_W-1:0]  stack_data,
  output logic                  pc_load,
  output logic [`PC_W-1:0]      pc_out,
  output core_word_pkg::sp_t    sp_out,
  output logic                  irq_busy
);

  import irq_src_pkg::*;
  import core_word_pkg::*;

  localparam logic [1:0] PUSH_LAST = 2'(`PUSH_COUNT - 1);

  typedef enum logic [2:0] {
    IDLE,
    WAKE,  // Extra cycle to leave halt
    TAKE,
    PUSH,
    LOAD
  } state_t;

  state_t   state;
  state_t   state_nxt;
  logic     accept;
  logic [1:0] push_cnt;

  // Captured at acceptance
  irq_vec_t vec_q;
  irq_src_t src_q;
  pc_word_u pc_q;
  sp_t      addr_q;

  // A halted core has no instruction boundary to wait for
  assign accept = (state == IDLE) && req_any && irq_enable && (instr_done || halted);

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (accept) begin
          state_nxt = halted ? WAKE : TAKE;
        end
      end
      WAKE: state_nxt = TAKE;
      TAKE: state_nxt = PUSH;
      PUSH: begin
        if (push_cnt == 2'd0) begin
          state_nxt = LOAD;
        end
      end
      LOAD: state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Counts down so it indexes the nibble view directly
  always_ff @(posedge clk) begin
    if (reset) begin
      push_cnt <= '0;
    end else if (state == TAKE) begin
      push_cnt <= PUSH_LAST;
    end else if (state == PUSH && push_cnt != 2'd0) begin
      push_cnt <= push_cnt - 2'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      vec_q  <= req_vector;
      src_q  <= req_src;
      pc_q   <= pc_in[11:0];  // Bank bit is not stacked
      addr_q <= sp_in - 1'b1;
    end else if (state == PUSH && push_cnt != 2'd0) begin
      addr_q <= addr_q - 1'b1;
    end
  end

  // Enable flag cleared and factor flag acknowledged together
  assign ie_clear  = (state == TAKE);
  assign ack_valid = (state == TAKE);
  assign ack_src   = src_q;

  assign stack_we   = (state == PUSH);
  assign stack_addr = addr_q;
  assign stack_data = pc_q.nib[push_cnt];

  // Stack address stops at sp_in - 3 after the last push
  assign pc_load = (state == LOAD);
  assign pc_out  = vec_q;
  assign sp_out  = addr_q;

  assign irq_busy = (state != IDLE);

endmodule

// File: design/irq_subsystem.sv
`timescale 1ns/1ps
`include "irq_defines.svh"

// Interrupt path: factor latch, priority resolve, sequencer
module irq_subsystem (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`IRQ_NUM_SRC-1:0] src_event,
  input  logic [`IRQ_NUM_SRC-1:0] src_mask,
  input  logic                    irq_enable,
  input  logic                    instr_done,
  input  logic                    halted,
  input  logic [`PC_W-1:0]        pc_in,
  input  core_word_pkg::sp_t      sp_in,
  output logic                    ie_clear,
  output logic                    stack_we,
  output core_word_pkg::sp_t      stack_addr,
  output logic [`NIBBLE_W-1:0]    stack_data,
  output logic                    pc_load,
  output logic [`PC_W-1:0]        pc_out,
  output core_word_pkg::sp_t      sp_out,
  output logic                    irq_busy,
  output irq_src_pkg::irq_src_t   irq_taken_src
);

  logic [`IRQ_NUM_SRC-1:0] req_vec;
  logic                    req_any;
  irq_src_pkg::irq_src_t   req_src;
  irq_src_pkg::irq_vec_t   req_vector;
  logic                    ack_valid;

  factor_latch factor_latch_inst (
    .clk       (clk),
    .reset     (reset),
    .src_event (src_event),
    .src_mask  (src_mask),
    .ack_valid (ack_valid),
    .ack_src   (irq_taken_src),
    .req_vec   (req_vec)
  );

  irq_priority irq_priority_inst (
    .clk        (clk),
    .reset      (reset),
    .req_vec    (req_vec),
    .req_any    (req_any),
    .req_src    (req_src),
    .req_vector (req_vector)
  );

  // The acknowledged source is also the one reported as taken
  irq_sequencer irq_sequencer_inst (
    .clk        (clk),
    .reset      (reset),
    .req_any    (req_any),
    .req_src    (req_src),
    .req_vector (req_vector),
    .irq_enable (irq_enable),
    .instr_done (instr_done),
    .halted     (halted),
    .pc_in      (pc_in),
    .sp_in      (sp_in),
    .ack_valid  (ack_valid),
    .ack_src    (irq_taken_src),
    .ie_clear   (ie_clear),
    .stack_we   (stack_we),
    .stack_addr (stack_addr),
    .stack_data (stack_data),
    .pc_load    (pc_load),
    .pc_out     (pc_out),
    .sp_out     (sp_out),
    .irq_busy   (irq_busy)
  );

endmodule

// File: tb/irq_subsystem_asserts.sv
`timescale 1ns/1ps

// Output rules of the interrupt sequencer
module irq_subsystem_asserts (
  input logic clk,
  input logic reset,
  input logic ie_clear,
  input logic stack_we,
  input logic pc_load
);

  // Never a fourth push in a row
  push_max: assert property (@(posedge clk) disable iff (reset)
    !(stack_we && $past(stack_we) && $past(stack_we, 2) && $past(stack_we, 3)))
    else $error("stack_we high for more than three cycles");

  // End of a push burst needs three pushes before it
  push_min: assert property (@(posedge clk) disable iff (reset)
    (!stack_we && $past(stack_we)) |-> ($past(stack_we, 2) && $past(stack_we, 3)))
    else $error("stack_we burst shorter than three cycles");

  // Vector load right after the last push
  load_after_push: assert property (@(posedge clk) disable iff (reset)
    (!stack_we && $past(stack_we)) |-> pc_load)
    else $error("pc_load missing after the third push");

  load_single: assert property (@(posedge clk) disable iff (reset)
    pc_load |-> (!$past(pc_load) && $past(stack_we)))
    else $error("pc_load not a single cycle following a push");

  // ie_clear pulse leads straight into the pushes
  clear_before_push: assert property (@(posedge clk) disable iff (reset)
    ie_clear |=> (stack_we && !ie_clear))
    else $error("ie_clear not followed by the push burst");

endmodule

bind irq_sequencer irq_subsystem_asserts irq_subsystem_asserts_inst (
  .clk      (clk),
  .reset    (reset),
  .ie_clear (ie_clear),
  .stack_we (stack_we),
  .pc_load  (pc_load)
);

// File: tb/irq_subsystem_tb.sv
`timescale 1ns/1ps
`include "irq_defines.svh"

// Testbench for the interrupt path
module irq_subsystem_tb;

  import irq_src_pkg::*;
  import core_word_pkg::*;

  localparam int NUM_DIRECTED = 13;
  localparam int NUM_RANDOM   = 40;
  localparam int TIMEOUT_CYC  = (NUM_DIRECTED + NUM_RANDOM) * 10 + 200;

  // Priority code per source, src_event order
  localparam logic [2:0] PRIO_CODE [`IRQ_NUM_SRC] = '{3'd1, 3'd2, 3'd3, 3'd4, 3'd6};

  typedef struct packed {
    logic [2:0]                          src;
    logic [`IRQ_NUM_SRC-1:0]             onehot;
    logic [`PC_W-1:0]                    vector;
    logic [`SP_W-1:0]                    sp_out;
    logic [`PUSH_COUNT-1:0][`SP_W-1:0]   addr;  // Push order
    logic [`PUSH_COUNT-1:0][`NIBBLE_W-1:0] nib;
    logic [31:0]                         take_cyc;  // Cycle count at the accepting edge
    logic [31:0]                         load_cyc;
  } exp_t;

  logic                    clk;
  logic                    reset;
  logic [`IRQ_NUM_SRC-1:0] src_event;
  logic [`IRQ_NUM_SRC-1:0] src_mask;
  logic                    irq_enable;
  logic                    instr_done;
  logic                    halted;
  logic [`PC_W-1:0]        pc_in;
  sp_t                     sp_in;
  logic                    ie_clear;
  logic                    stack_we;
  sp_t                     stack_addr;
  logic [`NIBBLE_W-1:0]    stack_data;
  logic                    pc_load;
  logic [`PC_W-1:0]        pc_out;
  sp_t                     sp_out;
  logic                    irq_busy;
  irq_src_t                irq_taken_src;

  logic [`IRQ_NUM_SRC-1:0] model_flags;
  logic [`IRQ_NUM_SRC-1:0] model_ack;  // Flag cleared by the expected acknowledge
  logic                    busy_exp;
  exp_t                    exp_q[$];
  int unsigned             cyc = 0;
  int                      push_idx = 0;
  int                      loads_seen = 0;
  int                      exp_loads = 0;
  int                      pending_loads = 0;
  integer                  seed = 32'h991;

  irq_subsystem irq_subsystem_inst (
    .clk           (clk),
    .reset         (reset),
    .src_event     (src_event),
    .src_mask      (src_mask),
    .irq_enable    (irq_enable),
    .instr_done    (instr_done),
    .halted        (halted),
    .pc_in         (pc_in),
    .sp_in         (sp_in),
    .ie_clear      (ie_clear),
    .stack_we      (stack_we),
    .stack_addr    (stack_addr),
    .stack_data    (stack_data),
    .pc_load       (pc_load),
    .pc_out        (pc_out),
    .sp_out        (sp_out),
    .irq_busy      (irq_busy),
    .irq_taken_src (irq_taken_src)
  );

  always #20 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH at %0t: %s is %0h, expected %0h", $time, name, got, exp));
    end
  endtask

  // Highest code wins, vector two words per code
  function automatic exp_t predict_take(input logic [`IRQ_NUM_SRC-1:0] pending,
                                        input logic [`PC_W-1:0] pc, input sp_t sp);
    exp_t e;
    e = '0;
    for (int i = 0; i < `IRQ_NUM_SRC; i++) begin
      if (pending[i] && PRIO_CODE[i] > e.src) begin
        e.src       = PRIO_CODE[i];
        e.onehot    = '0;
        e.onehot[i] = 1'b1;
      end
    end
    e.vector = `IRQ_VEC_PAGE + {9'd0, e.src, 1'b0};
    for (int k = 0; k < `PUSH_COUNT; k++) begin
      e.addr[k] = sp - 8'(k + 1);
      e.nib[k]  = pc[11 - 4 * k -: 4];  // High nibble first
    end
    e.sp_out = sp - 8'd3;
    return e;
  endfunction

  // Flag model, same set and clear rule as the factor flags
  always @(posedge clk) begin
    if (reset) begin
      model_flags <= '0;
    end else begin
      model_flags <= (model_flags & ~model_ack) | src_event;
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYC) begin
      abort_run($sformatf("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC));
    end
  end

  // Compare process, outputs sampled before the edge updates them
  always @(posedge clk) begin
    if (!reset) begin
      // Busy from the cycle after acceptance up to the vector load
      busy_exp = 1'b0;
      if (exp_q.size() != 0) begin
        busy_exp = (cyc > exp_q[0].take_cyc) && (cyc <= exp_q[0].load_cyc);
      end
      check_value("irq_busy", 32'(irq_busy), 32'(busy_exp));
      if (ie_clear) begin
        if (exp_q.size() == 0) begin
          abort_run("ie_clear pulsed while no interrupt was expected");
        end else begin
          check_value("ie_clear cycle", cyc, exp_q[0].load_cyc - 4);
        end
      end
      if (stack_we) begin
        if (exp_q.size() == 0 || push_idx >= `PUSH_COUNT) begin
          abort_run("stack write outside an expected push sequence");
        end else begin
          check_value("stack_addr", 32'(stack_addr), 32'(exp_q[0].addr[push_idx]));
          check_value("stack_data", 32'(stack_data), 32'(exp_q[0].nib[push_idx]));
          push_idx = push_idx + 1;
        end
      end
      if (pc_load) begin
        if (exp_q.size() == 0) begin
          abort_run("pc_load pulsed while no interrupt was expected");
        end else begin
          check_value("pc_out", 32'(pc_out), 32'(exp_q[0].vector));
          check_value("sp_out", 32'(sp_out), 32'(exp_q[0].sp_out));
          check_value("irq_taken_src", 32'(irq_taken_src), 32'(exp_q[0].src));
          check_value("pc_load cycle", cyc, exp_q[0].load_cyc);
          check_value("stack writes", push_idx, `PUSH_COUNT);
          exp_q.delete(0);
          push_idx      = 0;
          loads_seen    = loads_seen + 1;
          pending_loads = pending_loads - 1;
        end
      end
    end
  end

  // Events and masks, two settle cycles, then a boundary
  // busy_ev arrives busy_at cycles after acceptance
  task automatic run_boundary(input logic [4:0] ev, input logic [4:0] mask, input logic en,
                              input logic use_halt, input logic [4:0] busy_ev,
                              input int busy_at);
    exp_t        e;
    logic        take;
    logic [31:0] r;
    @(negedge clk);
    src_event  = ev;
    src_mask   = mask;
    irq_enable = en;
    @(negedge clk);
    src_event = '0;
    @(negedge clk);
    r     = $random(seed);
    pc_in = r[12:0];
    sp_in = r[23:16];
    take  = en && ((model_flags & src_mask) != '0);
    e     = predict_take(model_flags & src_mask, pc_in, sp_in);
    if (take) begin
      e.take_cyc = cyc;
      e.load_cyc = cyc + (use_halt ? 6 : 5);  // Wake cycle when halted
      exp_q.push_back(e);
      exp_loads     = exp_loads + 1;
      pending_loads = pending_loads + 1;
    end
    if (use_halt) begin
      halted = 1'b1;
    end else begin
      instr_done = 1'b1;
    end
    for (int k = 0; k < 6; k++) begin
      @(negedge clk);
      instr_done = 1'b0;
      halted     = 1'b0;
      model_ack  = (take && k == (use_halt ? 1 : 0)) ? e.onehot : '0;
      src_event  = (k == busy_at) ? busy_ev : '0;
    end
    @(negedge clk);
    model_ack = '0;
    src_event = '0;
    while (pending_loads != 0) begin
      @(negedge clk);
    end
  endtask

  initial begin
    logic [31:0] r;
    clk        = 1'b0;
    reset      = 1'b1;
    src_event  = '0;
    src_mask   = '0;
    irq_enable = 1'b1;
    instr_done = 1'b0;
    halted     = 1'b0;
    pc_in      = '0;
    sp_in      = '0;
    model_ack  = '0;
    repeat (4) @(negedge clk);
    reset = 1'b0;

    run_boundary(5'b00001, 5'b11111, 1'b1, 1'b0, '0, 0);  // Clock timer alone
    // Three at once, prog timer then K1 then K0
    run_boundary(5'b11100, 5'b11111, 1'b1, 1'b0, '0, 0);
    run_boundary('0, 5'b11111, 1'b1, 1'b0, '0, 0);
    run_boundary('0, 5'b11111, 1'b1, 1'b0, '0, 0);
    // Masked stopwatch waits for its mask
    run_boundary(5'b00010, 5'b11101, 1'b1, 1'b0, '0, 0);
    run_boundary('0, 5'b11101, 1'b1, 1'b0, '0, 0);
    run_boundary('0, 5'b11111, 1'b1, 1'b0, '0, 0);
    run_boundary(5'b01000, 5'b11111, 1'b0, 1'b0, '0, 0);  // Enable low
    run_boundary('0, 5'b11111, 1'b1, 1'b1, '0, 0);        // Halted core
    // Repeat event in the ack cycle, then later in the sequence
    run_boundary(5'b00100, 5'b11111, 1'b1, 1'b0, 5'b00100, 0);
    run_boundary('0, 5'b11111, 1'b1, 1'b0, '0, 0);
    run_boundary(5'b10000, 5'b11111, 1'b1, 1'b0, 5'b10000, 3);
    run_boundary('0, 5'b11111, 1'b1, 1'b0, '0, 0);

    for (int n = 0; n < NUM_RANDOM; n++) begin
      r = $random(seed);
      run_boundary(r[4:0], r[9:5] | r[14:10], r[18:16] != 3'd0, r[20:19] == 2'd0,
                   (r[22:21] == 2'd0) ? r[27:23] : 5'd0, int'(r[31:28]) % 6);
    end

    repeat (4) @(negedge clk);
    if (loads_seen == exp_loads && exp_q.size() == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      abort_run($sformatf("Expected %0d vector loads but saw %0d", exp_loads, loads_seen));
    end
  end

endmodule

// File: verilog.f
+incdir+include
design/irq_src_pkg.sv
design/core_word_pkg.sv
design/factor_latch.sv
design/irq_priority.sv
design/irq_sequencer.sv
design/irq_subsystem.sv
tb/irq_subsystem_asserts.sv
tb/irq_subsystem_tb.sv

// File: Makefile
# Verilator build and run of the interrupt path testbench

VERILATOR ?= verilator
TOP       ?= irq_subsystem_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
